//--- cache_defines.svh
/*
  size and shape macros for the write-back cache
  included by the cache package and by the testbench
*/
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address width
`define CACHE_ADDR_BITS 32

// word width on the upper side
`define CACHE_WORD_BITS 64

`define CACHE_LINE_BYTES 16  // bytes per line
`define CACHE_WAYS 2         // associativity
`define CACHE_SETS 4         // number of sets

`endif

//--- cache_pkg.sv
/*
  shared types for the cache, derived widths and the port structs
  modules pull it in with a wildcard import in their header
*/
`include "cache_defines.svh"

package cache_pkg;

  localparam int ADDR_BITS     = `CACHE_ADDR_BITS;
  localparam int WORD_BITS     = `CACHE_WORD_BITS;
  localparam int LINE_BYTES    = `CACHE_LINE_BYTES;
  localparam int LINE_BITS     = LINE_BYTES * 8;
  localparam int NUM_WAYS      = `CACHE_WAYS;
  localparam int NUM_SETS      = `CACHE_SETS;
  localparam int OFFSET_BITS   = $clog2(LINE_BYTES);
  localparam int SET_BITS      = $clog2(NUM_SETS);
  localparam int WAY_BITS      = $clog2(NUM_WAYS);
  localparam int TAG_BITS      = ADDR_BITS - SET_BITS - OFFSET_BITS;
  localparam int WORD_OFF_BITS = $clog2(WORD_BITS / 8);     // byte bits inside a word
  localparam int WSEL_BITS     = OFFSET_BITS - WORD_OFF_BITS; // word index inside a line

  typedef logic [ADDR_BITS-1:0]   addr_t;
  typedef logic [WORD_BITS-1:0]   word_t;
  typedef logic [LINE_BITS-1:0]   line_t;
  typedef logic [TAG_BITS-1:0]    tag_t;
  typedef logic [SET_BITS-1:0]    set_idx_t;
  typedef logic [OFFSET_BITS-1:0] offset_t;
  typedef logic [WAY_BITS-1:0]    way_idx_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    word_t value;
  } hc_req_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t value;
  } hc_resp_t;

  typedef struct packed {
    logic  valid;
    logic  we;     // high for a write-back
    addr_t addr;   // always line aligned
    line_t line;
  } lc_req_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    line_t line;
  } lc_fill_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_REQ,
    EVICT,
    INSTALL,
    RESPOND,
    FLUSH
  } ctrl_state_t;

endpackage

//--- cache_tag_store.sv
/*
  tag, valid and dirty bits for every way and set, with parallel hit compare
  also keeps the round-robin victim pointer of each set
*/
`timescale 1ns/1ns

module cache_tag_store
  import cache_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_N_in,
  input  set_idx_t   lookup_set,
  input  tag_t       lookup_tag,
  output logic       hit,
  output way_idx_t   hit_way,
  output way_idx_t   victim_way,
  output tag_entry_t victim_entry,
  input  logic       upd_en,      // write entry of upd_way in lookup_set
  input  way_idx_t   upd_way,
  input  tag_entry_t upd_entry,
  input  logic       touch_en,    // move pointer of lookup_set past touch_way
  input  way_idx_t   touch_way,
  input  logic       flush_en
);

  tag_entry_t entry_q [NUM_WAYS][NUM_SETS];
  way_idx_t   ptr_q [NUM_SETS];   // next victim per set

  // compare every way of the set at once
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (entry_q[w][lookup_set].valid && (entry_q[w][lookup_set].tag == lookup_tag)) begin
        hit     = 1'b1;
        hit_way = way_idx_t'(w);
      end
    end
  end

  assign victim_way   = ptr_q[lookup_set];
  assign victim_entry = entry_q[victim_way][lookup_set];  // needed for write-back decision

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          entry_q[w][s] <= '0;
        end
      end
      for (int s = 0; s < NUM_SETS; s++) begin
        ptr_q[s] <= '0;
      end
    end else begin
      if (flush_en) begin
        // only the valid bits, pointers keep their place
        for (int w = 0; w < NUM_WAYS; w++) begin
          for (int s = 0; s < NUM_SETS; s++) begin
            entry_q[w][s].valid <= 1'b0;
          end
        end
      end else if (upd_en) begin
        entry_q[upd_way][lookup_set] <= upd_entry;
      end
      if (touch_en) begin
        ptr_q[lookup_set] <= (touch_way == way_idx_t'(NUM_WAYS - 1)) ? '0 : touch_way + 1'b1;
      end
    end
  end

endmodule

//--- cache_data_store.sv
/*
  line storage for all ways and sets, read combinationally
  writes either a whole line on a fill or one merged word on a write hit
*/
`timescale 1ns/1ns

module cache_data_store
  import cache_pkg::*;
(
  input  logic     clk_in,
  input  way_idx_t rd_way,
  input  set_idx_t rd_set,
  input  offset_t  rd_offset,
  output word_t    rd_word,
  output line_t    rd_line,
  input  logic     wr_line_en,
  input  logic     wr_word_en,
  input  way_idx_t wr_way,
  input  set_idx_t wr_set,
  input  offset_t  wr_offset,
  input  word_t    wr_word,
  input  line_t    wr_line
);

  line_t mem_q [NUM_WAYS][NUM_SETS];

  logic [WSEL_BITS-1:0] rd_sel;  // word slot of the read offset
  logic [WSEL_BITS-1:0] wr_sel;

  // low byte bits dropped so the word is 8-byte aligned
  assign rd_sel = rd_offset[OFFSET_BITS-1:WORD_OFF_BITS];
  assign wr_sel = wr_offset[OFFSET_BITS-1:WORD_OFF_BITS];

  assign rd_line = mem_q[rd_way][rd_set];
  assign rd_word = rd_line[rd_sel*WORD_BITS +: WORD_BITS];

  always_ff @(posedge clk_in) begin
    if (wr_line_en) begin
      mem_q[wr_way][wr_set] <= wr_line;  // fill replaces the line
    end else if (wr_word_en) begin
      mem_q[wr_way][wr_set][wr_sel*WORD_BITS +: WORD_BITS] <= wr_word;  // merge one word
    end
  end

endmodule

//--- cache_ctrl.sv
/*
  cache controller, takes one item at a time from the upper or lower side
  runs the lookup, miss, write-back and install sequence on the two stores
  all outputs toward both sides come straight from registers
*/
`timescale 1ns/1ns

module cache_ctrl
  import cache_pkg::*;
(
  input  logic       clk_in,
  input  logic       rst_N_in,
  input  logic       flush_in,
  input  hc_req_t    hc_req,
  input  logic       hc_ready_in,
  input  lc_fill_t   lc_fill,
  input  logic       lc_ready_in,
  output hc_resp_t   hc_resp,
  output logic       hc_ready_out,
  output lc_req_t    lc_req,
  output logic       lc_ready_out,
  output set_idx_t   lookup_set,
  output tag_t       lookup_tag,
  input  logic       hit,
  input  way_idx_t   hit_way,
  input  way_idx_t   victim_way,
  input  tag_entry_t victim_entry,
  output logic       upd_en,
  output way_idx_t   upd_way,
  output tag_entry_t upd_entry,
  output logic       touch_en,
  output way_idx_t   touch_way,
  output logic       flush_en,
  output way_idx_t   rd_way,
  output set_idx_t   rd_set,
  output offset_t    rd_offset,
  input  word_t      rd_word,
  input  line_t      rd_line,
  output logic       wr_line_en,
  output logic       wr_word_en,
  output way_idx_t   wr_way,
  output set_idx_t   wr_set,
  output offset_t    wr_offset,
  output word_t      wr_word,
  output line_t      wr_line
);

  ctrl_state_t state_q, state_d;

  logic     is_fill_q;  // item came from below
  logic     we_q;
  addr_t    addr_q;
  word_t    word_q;
  line_t    line_q;
  way_idx_t way_q;      // way chosen in lookup for the install

  tag_t     cur_tag;
  set_idx_t cur_set;
  offset_t  cur_offset;

  assign {cur_tag, cur_set, cur_offset} = addr_q;

  assign lookup_set = cur_set;
  assign lookup_tag = cur_tag;

  // a fill reads out the victim, an upper request reads the hit way
  assign rd_way    = is_fill_q ? victim_way : hit_way;
  assign rd_set    = cur_set;
  assign rd_offset = cur_offset;

  assign upd_en    = (state_q == INSTALL);
  assign upd_way   = way_q;
  assign upd_entry = '{valid: 1'b1, dirty: ~is_fill_q, tag: cur_tag};  // fills go in clean
  assign flush_en  = (state_q == FLUSH);

  assign wr_line_en = (state_q == INSTALL) && is_fill_q;
  assign wr_word_en = (state_q == INSTALL) && !is_fill_q;
  assign wr_way     = way_q;
  assign wr_set     = cur_set;
  assign wr_offset  = cur_offset;
  assign wr_word    = word_q;
  assign wr_line    = line_q;

  always_comb begin
    state_d   = state_q;
    touch_en  = 1'b0;
    touch_way = hit_way;
    case (state_q)
      IDLE: begin
        if (flush_in) begin
          state_d = FLUSH;                 // flush wins over everything
        end else if (lc_fill.valid || hc_req.valid) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (is_fill_q) begin
          if (victim_entry.valid && victim_entry.dirty) begin
            state_d = EVICT;
          end else begin
            state_d = INSTALL;
          end
        end else if (!hit) begin
          state_d = MISS_REQ;              // requester retries after the fill
        end else if (we_q) begin
          state_d = INSTALL;               // word merge, line turns dirty
        end else begin
          state_d  = RESPOND;
          touch_en = 1'b1;                 // read hit touches now
        end
      end
      MISS_REQ: if (lc_ready_in) state_d = IDLE;
      EVICT:    if (lc_ready_in) state_d = INSTALL;
      INSTALL: begin
        state_d   = IDLE;
        touch_en  = 1'b1;
        touch_way = way_q;
      end
      RESPOND:  if (hc_ready_in) state_d = IDLE;
      FLUSH:    state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q      <= IDLE;
      is_fill_q    <= 1'b0;
      we_q         <= 1'b0;
      hc_resp      <= '0;
      lc_req       <= '0;
      hc_ready_out <= 1'b0;
      lc_ready_out <= 1'b0;
    end else begin
      state_q      <= state_d;
      // upper item is acked on acceptance, a fill only once it is installed
      hc_ready_out <= (state_q == IDLE) && (state_d == LOOKUP) && !lc_fill.valid;
      lc_ready_out <= is_fill_q && (state_d == INSTALL);
      if (state_q == IDLE) begin
        is_fill_q <= lc_fill.valid;
        we_q      <= !lc_fill.valid && hc_req.we;
      end
      case (state_q)
        LOOKUP: begin
          if (state_d == RESPOND) begin
            hc_resp <= '{valid: 1'b1, addr: addr_q, value: rd_word};
          end else if (state_d == MISS_REQ) begin
            lc_req <= '{valid: 1'b1, we: 1'b0,
                        addr: {cur_tag, cur_set, {OFFSET_BITS{1'b0}}}, line: '0};
          end else if (state_d == EVICT) begin
            // victim address rebuilt from its stored tag
            lc_req <= '{valid: 1'b1, we: 1'b1,
                        addr: {victim_entry.tag, cur_set, {OFFSET_BITS{1'b0}}}, line: rd_line};
          end
        end
        MISS_REQ, EVICT: if (lc_ready_in) lc_req.valid <= 1'b0;
        RESPOND:         if (hc_ready_in) hc_resp.valid <= 1'b0;
        default: ;
      endcase
    end
  end

  // payload of the accepted item, no reset
  always_ff @(posedge clk_in) begin
    if (state_q == IDLE) begin
      addr_q <= lc_fill.valid ? lc_fill.addr : hc_req.addr;
      word_q <= hc_req.value;
      line_q <= lc_fill.line;
    end
    if (state_q == LOOKUP) begin
      way_q <= (is_fill_q && !hit) ? victim_way : hit_way;  // fill of a present line reuses it
    end
  end

endmodule

//--- cache_top.sv
/*
  top level of the write-back set-associative cache
  word requests from above, line requests and fills from below
*/
`timescale 1ns/1ns

module cache_top
  import cache_pkg::*;
(
  input  logic     clk_in,
  input  logic     rst_N_in,
  input  logic     flush_in,
  input  hc_req_t  hc_req,
  input  logic     hc_ready_in,
  output hc_resp_t hc_resp,
  output logic     hc_ready_out,
  input  lc_fill_t lc_fill,
  input  logic     lc_ready_in,
  output lc_req_t  lc_req,
  output logic     lc_ready_out
);

  // tag store side
  set_idx_t   lookup_set;
  tag_t       lookup_tag;
  logic       hit;
  way_idx_t   hit_way, victim_way;
  tag_entry_t victim_entry;
  logic       upd_en, touch_en, flush_en;
  way_idx_t   upd_way, touch_way;
  tag_entry_t upd_entry;

  // data store side
  way_idx_t   rd_way, wr_way;
  set_idx_t   rd_set, wr_set;
  offset_t    rd_offset, wr_offset;
  word_t      rd_word, wr_word;
  line_t      rd_line, wr_line;
  logic       wr_line_en, wr_word_en;

  cache_ctrl u_ctrl (.*);

  cache_tag_store u_tags (.*);

  cache_data_store u_data (.*);

endmodule

//--- cache_tb.sv
/*
  directed testbench for the write-back cache top level
  a small model of tags, dirty bits, victim pointers and lines predicts every response
  inputs change on the falling edge, outputs are sampled there too
*/
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 10;
  localparam int WAYS          = `CACHE_WAYS;
  localparam int SETS          = `CACHE_SETS;
  localparam int WORD_BYTES    = `CACHE_WORD_BITS / 8;
  localparam int NUM_TESTS     = 6;
  localparam int TXNS_PER_TEST = 6;   // upper bound of transactions in one test
  localparam int MAX_STALL     = 20;  // longest back-pressure in cycles
  localparam int TIMEOUT_NS    =
    (RESET_CYCLES + NUM_TESTS * TXNS_PER_TEST * (MAX_STALL + 12)) * CLK_PERIOD;

  logic     clk_in, rst_N_in, flush_in;
  logic     hc_ready_in, lc_ready_in;
  logic     hc_ready_out, lc_ready_out;
  hc_req_t  hc_req;
  hc_resp_t hc_resp;
  lc_fill_t lc_fill;
  lc_req_t  lc_req;

  // reference model state
  logic     m_valid [WAYS][SETS];
  logic     m_dirty [WAYS][SETS];
  tag_t     m_tag [WAYS][SETS];
  line_t    m_line [WAYS][SETS];
  way_idx_t m_ptr [SETS];

  logic [31:0] lfsr_q;
  addr_t       shared_addr;  // line kept between the miss and write tests

  cache_top dut (.*);

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Verification failed");
    $fatal(1, "timeout after %0d ns, the DUT stopped handshaking", TIMEOUT_NS);
  end

  // taps of x^32 + x^22 + x^2 + x + 1 with one step per bit
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[62:0], fb};
    end
    return r;
  endfunction

  task automatic check_value(input logic [255:0] exp, input logic [255:0] act,
                             input string msg);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s, expected %0h, got %0h", $time, msg, exp, act);
      $display("Verification failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  function automatic set_idx_t set_of(input addr_t a);
    return a[OFFSET_BITS +: SET_BITS];
  endfunction

  function automatic tag_t tag_of(input addr_t a);
    return a[ADDR_BITS-1 -: TAG_BITS];
  endfunction

  function automatic int word_sel(input addr_t a);
    return int'(a[OFFSET_BITS-1:0]) / WORD_BYTES;  // word slot of the 8-byte aligned offset
  endfunction

  function automatic addr_t line_of(input addr_t a);
    return {a[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  endfunction

  function automatic addr_t line_addr(input tag_t t, input set_idx_t s);
    return {t, s, {OFFSET_BITS{1'b0}}};
  endfunction

  function automatic addr_t rand_addr(input set_idx_t s);
    return {tag_t'(lfsr_bits(TAG_BITS)), s, offset_t'(lfsr_bits(OFFSET_BITS))};
  endfunction

  function automatic line_t rand_line();
    return {lfsr_bits(WORD_BITS), lfsr_bits(WORD_BITS)};
  endfunction

  function automatic int small_stall();
    return int'(lfsr_bits(2));
  endfunction

  function automatic logic find_line(input addr_t a, output way_idx_t way);
    logic found;
    found = 1'b0;
    way   = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[w][set_of(a)] && (m_tag[w][set_of(a)] == tag_of(a))) begin
        found = 1'b1;
        way   = way_idx_t'(w);
      end
    end
    return found;
  endfunction

  // pointer moves one past the used way
  function automatic void advance_victim(input set_idx_t s, input way_idx_t w);
    m_ptr[s] = way_idx_t'((int'(w) + 1) % WAYS);
  endfunction

  task automatic send_req(input logic we, input addr_t a, input word_t v);
    @(negedge clk_in);
    hc_req = '{valid: 1'b1, we: we, addr: a, value: v};
    @(negedge clk_in);
    while (!hc_ready_out) @(negedge clk_in);  // taken only while idle
    hc_req.valid = 1'b0;
  endtask

  task automatic wait_activity();
    while (!hc_resp.valid && !lc_req.valid) @(negedge clk_in);
  endtask

  task automatic accept_resp(input int stall);
    hc_resp_t held;
    held = hc_resp;
    repeat (stall) begin
      @(negedge clk_in);
      check_value(256'(held), 256'(hc_resp), "hc_resp changed under back-pressure");
    end
    hc_ready_in = 1'b1;
    @(negedge clk_in);
    hc_ready_in = 1'b0;
    check_value(256'(1'b0), 256'(hc_resp.valid), "hc_resp.valid high after ready");
  endtask

  task automatic accept_lc(input int stall);
    lc_req_t held;
    held = lc_req;
    repeat (stall) begin
      @(negedge clk_in);
      check_value(256'(held), 256'(lc_req), "lc_req changed under back-pressure");
    end
    lc_ready_in = 1'b1;
    @(negedge clk_in);
    lc_ready_in = 1'b0;
    check_value(256'(1'b0), 256'(lc_req.valid), "lc_req.valid high after ready");
  endtask

  task automatic expect_miss(input addr_t a);
    check_value(256'(1'b0), 256'(hc_resp.valid), "upper response on a miss");
    check_value(256'(1'b1), 256'(lc_req.valid), "no lower read on a miss");
    check_value(256'(1'b0), 256'(lc_req.we), "lower read marked as write");
    check_value(256'(line_of(a)), 256'(lc_req.addr), "lower read address");
  endtask

  task automatic read_word(input addr_t a, input int stall);
    way_idx_t w;
    logic     hit;
    line_t    exp_line;
    hit = find_line(a, w);
    send_req(1'b0, a, '0);
    wait_activity();
    if (hit) begin
      exp_line = m_line[w][set_of(a)];
      check_value(256'(1'b1), 256'(hc_resp.valid), "read hit gave no response");
      check_value(256'(a), 256'(hc_resp.addr), "read response address");
      check_value(256'(exp_line[word_sel(a)*WORD_BITS +: WORD_BITS]), 256'(hc_resp.value),
                  "read response word");
      advance_victim(set_of(a), w);
      accept_resp(stall);
    end else begin
      expect_miss(a);
      accept_lc(stall);
    end
  endtask

  task automatic write_word(input addr_t a, input word_t v, input int stall);
    way_idx_t w;
    logic     hit;
    hit = find_line(a, w);
    send_req(1'b1, a, v);
    if (hit) begin
      // merge the word and mark the line dirty
      m_line[w][set_of(a)][word_sel(a)*WORD_BITS +: WORD_BITS] = v;
      m_dirty[w][set_of(a)] = 1'b1;
      advance_victim(set_of(a), w);
    end else begin
      wait_activity();
      expect_miss(a);
      accept_lc(stall);
    end
  endtask

  task automatic send_fill(input addr_t a, input line_t ln, input int stall);
    way_idx_t w;
    way_idx_t victim;
    logic     hit;
    logic     wb_due;   // victim is dirty and goes down first
    set_idx_t s;
    s      = set_of(a);
    victim = m_ptr[s];
    hit    = find_line(a, w);
    wb_due = m_valid[victim][s] && m_dirty[victim][s];
    @(negedge clk_in);
    lc_fill = '{valid: 1'b1, addr: a, line: ln};
    @(negedge clk_in);
    while (!lc_ready_out && !lc_req.valid) @(negedge clk_in);
    if (wb_due) begin
      check_value(256'(1'b0), 256'(lc_ready_out), "fill acknowledged before write-back");
      check_value(256'(1'b1), 256'(lc_req.we), "write-back not marked as write");
      check_value(256'(line_addr(m_tag[victim][s], s)), 256'(lc_req.addr), "write-back address");
      check_value(256'(m_line[victim][s]), 256'(lc_req.line), "write-back line");
      accept_lc(stall);
    end else begin
      check_value(256'(1'b0), 256'(lc_req.valid), "lower request on a clean fill");
    end
    while (!lc_ready_out) @(negedge clk_in);
    lc_fill.valid = 1'b0;
    if (!hit) w = victim;  // present line is refilled in place
    m_valid[w][s] = 1'b1;
    m_dirty[w][s] = 1'b0;
    m_tag[w][s]   = tag_of(a);
    m_line[w][s]  = ln;
    advance_victim(s, w);
  endtask

  // called with the DUT idle, so the flush is taken on the next edge
  task automatic flush_pulse();
    @(negedge clk_in);
    flush_in = 1'b1;
    @(negedge clk_in);
    flush_in = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      for (int s = 0; s < SETS; s++) m_valid[w][s] = 1'b0;
    end
  endtask

  task automatic reset_outputs_low();
    repeat (5) begin
      @(negedge clk_in);
      check_value(256'(1'b0), 256'({hc_resp.valid, lc_req.valid, hc_ready_out, lc_ready_out}),
                  "control output high after reset");
    end
  endtask

  task automatic read_miss_then_fill();
    shared_addr = rand_addr(set_idx_t'(0));
    read_word(shared_addr, small_stall());                       // miss
    send_fill(line_of(shared_addr), rand_line(), small_stall());
    read_word(shared_addr, small_stall());                       // retry hits
  endtask

  task automatic write_hit_merge();
    write_word(shared_addr, word_t'(lfsr_bits(WORD_BITS)), 0);
    read_word(shared_addr, small_stall());
    read_word(shared_addr ^ addr_t'(WORD_BYTES), small_stall());  // other word untouched
  endtask

  task automatic dirty_eviction();
    addr_t    a;
    set_idx_t s;
    way_idx_t dirty_way;
    s = set_idx_t'(2);
    a = rand_addr(s);
    send_fill(line_of(a), rand_line(), 0);
    write_word(a, word_t'(lfsr_bits(WORD_BITS)), 0);
    void'(find_line(a, dirty_way));
    // clean fills step the pointer round to the dirty way
    while (m_ptr[s] != dirty_way) begin
      send_fill(line_of(rand_addr(s)), rand_line(), small_stall());
    end
    send_fill(line_of(rand_addr(s)), rand_line(), small_stall());  // dirty victim goes down
  endtask

  task automatic flush_invalidates();
    addr_t a;
    a = rand_addr(set_idx_t'(1));
    read_word(a, 0);
    send_fill(line_of(a), rand_line(), 0);
    read_word(a, small_stall());   // hits and leaves the DUT idle
    flush_pulse();
    read_word(a, small_stall());   // line is gone so the read misses again
  endtask

  task automatic backpressure_hold();
    addr_t a;
    addr_t b;
    a = rand_addr(set_idx_t'(3));
    b = rand_addr(set_idx_t'(3));
    read_word(a, 0);
    send_fill(line_of(a), rand_line(), 0);
    read_word(a, 4 + int'(lfsr_bits(4)));  // hc_ready_in held low
    read_word(b, 4 + int'(lfsr_bits(4)));  // miss with lc_ready_in held low
  endtask

  initial begin
    rst_N_in    = 1'b0;
    flush_in    = 1'b0;
    hc_ready_in = 1'b0;
    lc_ready_in = 1'b0;
    hc_req      = '0;
    lc_fill     = '0;
    lfsr_q      = 32'hc5bb4853;
    shared_addr = '0;
    for (int s = 0; s < SETS; s++) begin
      m_ptr[s] = '0;
      for (int w = 0; w < WAYS; w++) begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
        m_tag[w][s]   = '0;
        m_line[w][s]  = '0;
      end
    end
    repeat (RESET_CYCLES) @(negedge clk_in);
    rst_N_in = 1'b1;
    reset_outputs_low();
    read_miss_then_fill();
    write_hit_merge();
    dirty_eviction();
    flush_invalidates();
    backpressure_hold();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
cache_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_ctrl.sv
cache_top.sv
cache_tb.sv

//--- Makefile
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Verification passed

SRCS      := $(shell grep -v '^+' $(FILELIST)) cache_defines.svh
BIN       := $(BUILD_DIR)/V$(TOP)
CHECK_LOG  = grep -q "$(PASS_MSG)" $(LOG)

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@$(CHECK_LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

check:
	@$(CHECK_LOG) || { echo "no pass message in $(LOG)"; exit 1; }
	@echo "pass message found in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
